//--- rtl/ntm_fixed_pkg.sv
// Fixed-point weight format shared by the addressing pipeline, referenced by scoped names
`default_nettype none

package ntm_fixed_pkg;

  //////////////////////////////
  // Word format
  //////////////////////////////

  // One weighting element, all bits fractional
  localparam int WEIGHT_W = 8;

  // Binary point sits above the top bit, 255 reads as 255/256
  localparam int FRAC_BITS = 8;

  // Weighting element
  typedef logic [WEIGHT_W-1:0] weight_t;

  // Gate g or one shift tap, same fraction as a weight
  typedef logic [WEIGHT_W-1:0] gain_t;

  //////////////////////////////
  // Arithmetic constants
  //////////////////////////////

  // Largest element value, clamp point for the convolution
  localparam weight_t WEIGHT_MAX = 8'd255;

  // Exact 1.0, one bit wider than a gain so that 1 - g fits
  localparam logic [WEIGHT_W:0] ONE_FULL = 9'd256;

endpackage

`default_nettype wire

//--- rtl/ntm_head_pkg.sv
// Head control parameters carried through the addressing pipeline, referenced by scoped names
`default_nettype none

package ntm_head_pkg;

  // Sharpening exponent, only 1 to 3 are legal
  typedef logic [1:0] gamma_t;

  // Legal exponent range
  localparam gamma_t GAMMA_MIN = 2'd1;
  localparam gamma_t GAMMA_MAX = 2'd3;

  // Three-tap circular shift kernel
  typedef struct packed {
    ntm_fixed_pkg::gain_t tap_back;  // Offset -1
    ntm_fixed_pkg::gain_t tap_stay;  // Offset 0
    ntm_fixed_pkg::gain_t tap_fwd;   // Offset +1
  } shift_kernel_t;

  // Everything one request needs besides the weightings, 34 bits
  typedef struct packed {
    ntm_fixed_pkg::gain_t g;
    shift_kernel_t        shift;
    gamma_t               gamma;
  } head_params_t;

endpackage

`default_nettype wire

//--- rtl/ntm_interpolation.sv
// Gated blend of content and previous weightings, first step of the addressing pipeline
`timescale 1ns/1ps
`default_nettype none

module ntm_interpolation #(
  parameter int ELEMENTS = 8
) (
  input  logic                                        CLK,
  input  logic                                        RST,
  input  logic                                        in_valid,
  input  ntm_head_pkg::head_params_t                  head,
  input  ntm_fixed_pkg::weight_t [ELEMENTS-1:0]       wc,
  input  ntm_fixed_pkg::weight_t [ELEMENTS-1:0]       w_prev,
  output logic                                        out_valid,
  output ntm_head_pkg::head_params_t                  out_head,
  output ntm_fixed_pkg::weight_t [ELEMENTS-1:0]       wg
);

  // Two products plus carry
  localparam int SUM_W = 2 * ntm_fixed_pkg::WEIGHT_W + 1;

  //////////////////////////////
  // Blend datapath
  //////////////////////////////

  // 1 - g, needs the ninth bit when g is zero
  logic [ntm_fixed_pkg::WEIGHT_W:0] g_inv;
  logic [SUM_W-1:0] blend_sum [ELEMENTS];
  ntm_fixed_pkg::weight_t [ELEMENTS-1:0] wg_next;

  assign g_inv = ntm_fixed_pkg::ONE_FULL - {1'b0, head.g};

  // All elements in parallel
  always_comb begin
    for (int j = 0; j < ELEMENTS; j++) begin
      blend_sum[j] = SUM_W'(head.g * wc[j]) + SUM_W'(g_inv * w_prev[j]);
      // Weights of g and 1-g add to 1.0, so the top bit stays clear
      wg_next[j] = blend_sum[j][ntm_fixed_pkg::FRAC_BITS +: ntm_fixed_pkg::WEIGHT_W];
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  // Strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Payload, head travels alongside for the later steps
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      wg       <= wg_next;
      out_head <= head;
    end
  end

  // Blend result never leaves the span of its two sources
  for (genvar j = 0; j < ELEMENTS; j++) begin : g_span_chk
    a_blend_in_span: assert property (@(posedge CLK) disable iff (RST)
      out_valid |->
        ((wg[j] >= $past(wc[j])) && (wg[j] <= $past(w_prev[j]))) ||
        ((wg[j] <= $past(wc[j])) && (wg[j] >= $past(w_prev[j]))));
  end

endmodule

`default_nettype wire

//--- rtl/ntm_shift_convolution.sv
// Circular three-tap shift of the blended weighting, second step of the addressing pipeline
`timescale 1ns/1ps
`default_nettype none

module ntm_shift_convolution #(
  parameter int ELEMENTS = 8
) (
  input  logic                                        CLK,
  input  logic                                        RST,
  input  logic                                        in_valid,
  input  ntm_head_pkg::head_params_t                  head,
  input  ntm_fixed_pkg::weight_t [ELEMENTS-1:0]       wg,
  output logic                                        out_valid,
  output ntm_head_pkg::gamma_t                        gamma,
  output ntm_fixed_pkg::weight_t [ELEMENTS-1:0]       ws
);

  // Three products, two carry bits
  localparam int SUM_W = 2 * ntm_fixed_pkg::WEIGHT_W + 2;
  // Integer part left after dropping the fraction
  localparam int SHR_W = SUM_W - ntm_fixed_pkg::FRAC_BITS;
  // One tap times one weight
  localparam int PROD_W = 2 * ntm_fixed_pkg::WEIGHT_W;

  logic [SUM_W-1:0] conv_sum [ELEMENTS];
  logic [SHR_W-1:0] conv_shr [ELEMENTS];
  ntm_fixed_pkg::weight_t [ELEMENTS-1:0] ws_next;

  //////////////////////////////
  // Tap sum per element
  //////////////////////////////

  for (genvar j = 0; j < ELEMENTS; j++) begin : g_tap
    // Neighbour indices wrap around the ends
    localparam int IDX_BACK = (j + 1) % ELEMENTS;
    localparam int IDX_FWD  = (j + ELEMENTS - 1) % ELEMENTS;

    assign conv_sum[j] = SUM_W'(head.shift.tap_back * wg[IDX_BACK])
                       + SUM_W'(head.shift.tap_stay * wg[j])
                       + SUM_W'(head.shift.tap_fwd  * wg[IDX_FWD]);

    // Drop fraction
    assign conv_shr[j] = conv_sum[j][SUM_W-1:ntm_fixed_pkg::FRAC_BITS];

    // Clamp, taps are not required to sum to one
    assign ws_next[j] = (conv_shr[j] > SHR_W'(ntm_fixed_pkg::WEIGHT_MAX))
                      ? ntm_fixed_pkg::WEIGHT_MAX
                      : conv_shr[j][ntm_fixed_pkg::WEIGHT_W-1:0];
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Only gamma is still needed downstream
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      ws    <= ws_next;
      gamma <= head.gamma;
    end
  end

  // Clamp rather than wrap keeps every element above the centre tap alone
  for (genvar j = 0; j < ELEMENTS; j++) begin : g_sat_chk
    a_ws_saturated: assert property (@(posedge CLK) disable iff (RST)
      out_valid |->
        ws[j] >= ($past(PROD_W'(head.shift.tap_stay * wg[j])) >> ntm_fixed_pkg::FRAC_BITS));
  end

endmodule

`default_nettype wire

//--- rtl/ntm_sharpening.sv
// Power-by-gamma of every element over two stages, last step of the addressing pipeline
`timescale 1ns/1ps
`default_nettype none

module ntm_sharpening #(
  parameter int ELEMENTS = 8
) (
  input  logic                                        CLK,
  input  logic                                        RST,
  input  logic                                        in_valid,
  input  ntm_head_pkg::gamma_t                        gamma,
  input  ntm_fixed_pkg::weight_t [ELEMENTS-1:0]       ws,
  output logic                                        out_valid,
  output ntm_fixed_pkg::weight_t [ELEMENTS-1:0]       w_out
);

  // Full product of two weights
  localparam int PROD_W = 2 * ntm_fixed_pkg::WEIGHT_W;

  //////////////////////////////
  // Stage one, square
  //////////////////////////////

  logic [PROD_W-1:0] sq_prod [ELEMENTS];
  ntm_fixed_pkg::weight_t [ELEMENTS-1:0] sq_next;

  always_comb begin
    for (int j = 0; j < ELEMENTS; j++) begin
      sq_prod[j] = PROD_W'(ws[j] * ws[j]);
      // Truncate back to the weight fraction
      sq_next[j] = sq_prod[j][ntm_fixed_pkg::FRAC_BITS +: ntm_fixed_pkg::WEIGHT_W];
    end
  end

  logic                                  s1_valid;
  ntm_head_pkg::gamma_t                  s1_gamma;
  ntm_fixed_pkg::weight_t [ELEMENTS-1:0] s1_w;
  ntm_fixed_pkg::weight_t [ELEMENTS-1:0] s1_sq;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // Base kept for the cube and for gamma 1
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      s1_w     <= ws;
      s1_sq    <= sq_next;
      s1_gamma <= gamma;
    end
  end

  //////////////////////////////
  // Stage two, cube and select
  //////////////////////////////

  logic [PROD_W-1:0] cube_prod [ELEMENTS];
  ntm_fixed_pkg::weight_t [ELEMENTS-1:0] pow_sel;

  always_comb begin
    for (int j = 0; j < ELEMENTS; j++) begin
      // Square already truncated, so the cube truncates twice
      cube_prod[j] = PROD_W'(s1_sq[j] * s1_w[j]);
      case (s1_gamma)
        2'd2:    pow_sel[j] = s1_sq[j];
        2'd3:    pow_sel[j] = cube_prod[j][ntm_fixed_pkg::FRAC_BITS +: ntm_fixed_pkg::WEIGHT_W];
        // Gamma 1, and the illegal 0 falls back to it
        default: pow_sel[j] = s1_w[j];
      endcase
    end
  end

  // Result visible until the next request lands
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
      w_out     <= '0;
    end else begin
      out_valid <= s1_valid;
      if (s1_valid) begin
        w_out <= pow_sel;
      end
    end
  end

  // Exponent from the head must be in range by the time it gets here
  a_gamma_legal: assert property (@(posedge CLK) disable iff (RST)
    in_valid |-> (gamma >= ntm_head_pkg::GAMMA_MIN) && (gamma <= ntm_head_pkg::GAMMA_MAX));

endmodule

`default_nettype wire

//--- rtl/ntm_addressing.sv
// Top of the addressing pipeline, interpolation then shift then sharpening, four cycles deep
`timescale 1ns/1ps
`default_nettype none

module ntm_addressing #(
  parameter int ELEMENTS = 8
) (
  input  logic                                        CLK,
  input  logic                                        RST,
  input  logic                                        start,
  input  ntm_head_pkg::head_params_t                  head,
  input  ntm_fixed_pkg::weight_t [ELEMENTS-1:0]       wc,
  input  ntm_fixed_pkg::weight_t [ELEMENTS-1:0]       w_prev,
  output logic                                        done,
  output ntm_fixed_pkg::weight_t [ELEMENTS-1:0]       w_out
);

  //////////////////////////////
  // Stage links
  //////////////////////////////

  // Interpolation to convolution
  logic                                  conv_valid;
  ntm_head_pkg::head_params_t            conv_head;
  ntm_fixed_pkg::weight_t [ELEMENTS-1:0] wg;

  // Convolution to sharpening
  logic                                  sharp_valid;
  ntm_head_pkg::gamma_t                  sharp_gamma;
  ntm_fixed_pkg::weight_t [ELEMENTS-1:0] ws;

  //////////////////////////////
  // Pipeline steps
  //////////////////////////////

  // Captures the request on start, one cycle
  ntm_interpolation #(
    .ELEMENTS(ELEMENTS)
  ) u_interpolation (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (start),
    .head     (head),
    .wc       (wc),
    .w_prev   (w_prev),
    .out_valid(conv_valid),
    .out_head (conv_head),
    .wg       (wg)
  );

  // Circular shift, one cycle
  ntm_shift_convolution #(
    .ELEMENTS(ELEMENTS)
  ) u_shift_convolution (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (conv_valid),
    .head     (conv_head),
    .wg       (wg),
    .out_valid(sharp_valid),
    .gamma    (sharp_gamma),
    .ws       (ws)
  );

  // Power by gamma, two cycles, drives the result
  ntm_sharpening #(
    .ELEMENTS(ELEMENTS)
  ) u_sharpening (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (sharp_valid),
    .gamma    (sharp_gamma),
    .ws       (ws),
    .out_valid(done),
    .w_out    (w_out)
  );

endmodule

`default_nettype wire

//--- include/ntm_model.svh
// Reference arithmetic of the three addressing steps, included by the testbench for expected values
`ifndef NTM_MODEL_SVH
`define NTM_MODEL_SVH

// Gated blend of one element, truncating
function automatic ntm_fixed_pkg::weight_t model_blend(
  input ntm_fixed_pkg::gain_t   g,
  input ntm_fixed_pkg::weight_t wc,
  input ntm_fixed_pkg::weight_t wp
);
  int acc;
  acc = int'(g) * int'(wc) + (int'(ntm_fixed_pkg::ONE_FULL) - int'(g)) * int'(wp);
  return ntm_fixed_pkg::weight_t'(acc >> ntm_fixed_pkg::FRAC_BITS);
endfunction

// Three-tap sum for one element, clamped
function automatic ntm_fixed_pkg::weight_t model_shift(
  input ntm_head_pkg::shift_kernel_t k,
  input ntm_fixed_pkg::weight_t      back,
  input ntm_fixed_pkg::weight_t      stay,
  input ntm_fixed_pkg::weight_t      fwd
);
  int acc;
  acc = int'(k.tap_back) * int'(back) + int'(k.tap_stay) * int'(stay)
      + int'(k.tap_fwd) * int'(fwd);
  acc = acc >> ntm_fixed_pkg::FRAC_BITS;
  if (acc > int'(ntm_fixed_pkg::WEIGHT_MAX)) begin
    acc = int'(ntm_fixed_pkg::WEIGHT_MAX);
  end
  return ntm_fixed_pkg::weight_t'(acc);
endfunction

// Power with truncation after each multiply
function automatic ntm_fixed_pkg::weight_t model_power(
  input ntm_fixed_pkg::weight_t w,
  input ntm_head_pkg::gamma_t   gamma
);
  int p2;
  int p3;
  p2 = (int'(w) * int'(w)) >> ntm_fixed_pkg::FRAC_BITS;
  p3 = (p2 * int'(w)) >> ntm_fixed_pkg::FRAC_BITS;
  case (gamma)
    2'd2:    return ntm_fixed_pkg::weight_t'(p2);
    2'd3:    return ntm_fixed_pkg::weight_t'(p3);
    default: return w;
  endcase
endfunction

// Whole request, vector length taken from wc
function automatic void model_request(
  input  ntm_head_pkg::head_params_t h,
  input  ntm_fixed_pkg::weight_t     wc[],
  input  ntm_fixed_pkg::weight_t     wp[],
  output ntm_fixed_pkg::weight_t     w_out[]
);
  ntm_fixed_pkg::weight_t wg[];
  int n;
  n = wc.size();
  wg = new[n];
  w_out = new[n];
  for (int j = 0; j < n; j++) begin
    wg[j] = model_blend(h.g, wc[j], wp[j]);
  end
  for (int j = 0; j < n; j++) begin
    w_out[j] = model_power(model_shift(h.shift, wg[(j + 1) % n], wg[j], wg[(j + n - 1) % n]),
                           h.gamma);
  end
endfunction

`endif

//--- testbench/ntm_addressing_tb.sv
// Self-checking testbench for the addressing pipeline, built from tb.f and run by the Makefile
`timescale 1ns/1ps
`default_nettype none

module ntm_addressing_tb;

  localparam int ELEMENTS      = 8;
  // Counted from the edge that drives start
  localparam int LATENCY       = 4;
  localparam int DRAIN_TIMEOUT = 50;
  localparam int NUM_TESTS     = 6;
  localparam int RANDOM_REQS   = 300;

  typedef ntm_fixed_pkg::weight_t [ELEMENTS-1:0] vec_t;

  // One outstanding request as the monitor expects it
  typedef struct packed {
    int   test_id;
    int   issue_cycle;
    vec_t w;
  } expect_t;

  logic                       CLK;
  logic                       RST;
  logic                       start;
  ntm_head_pkg::head_params_t head;
  vec_t                       wc;
  vec_t                       w_prev;
  logic                       done;
  vec_t                       w_out;

  expect_t exp_q[$];
  int      cycle_cnt = 0;
  int      cur_test;
  int      test_checks [NUM_TESTS];
  int      test_errors [NUM_TESTS];
  string   test_names  [NUM_TESTS];

  `include "ntm_model.svh"

  ntm_addressing #(
    .ELEMENTS(ELEMENTS)
  ) UUT (
    .CLK   (CLK),
    .RST   (RST),
    .start (start),
    .head  (head),
    .wc    (wc),
    .w_prev(w_prev),
    .done  (done),
    .w_out (w_out)
  );

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////
  // Result monitor
  //////////////////////////////

  // Outputs settle after the rising edge, so look at them mid-cycle
  always @(negedge CLK) begin
    expect_t e;
    if (!RST && done) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected done at cycle %0d with no request outstanding", cycle_cnt);
        test_errors[cur_test]++;
      end else begin
        e = exp_q.pop_front();
        test_checks[e.test_id]++;
        if (cycle_cnt - e.issue_cycle != LATENCY) begin
          $display("ERROR %s latency: expected %0d actual %0d", test_names[e.test_id],
                   LATENCY, cycle_cnt - e.issue_cycle);
          test_errors[e.test_id]++;
        end
        for (int j = 0; j < ELEMENTS; j++) begin
          if (w_out[j] !== e.w[j]) begin
            $display("ERROR %s element %0d: expected %02h actual %02h",
                     test_names[e.test_id], j, e.w[j], w_out[j]);
            test_errors[e.test_id]++;
          end
        end
      end
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic vec_t random_vec();
    vec_t v;
    for (int j = 0; j < ELEMENTS; j++) begin
      v[j] = ntm_fixed_pkg::weight_t'($urandom);
    end
    return v;
  endfunction

  // Gamma always legal
  function automatic ntm_head_pkg::head_params_t random_head();
    ntm_head_pkg::head_params_t h;
    h.g              = ntm_fixed_pkg::gain_t'($urandom);
    h.shift.tap_back = ntm_fixed_pkg::gain_t'($urandom);
    h.shift.tap_stay = ntm_fixed_pkg::gain_t'($urandom);
    h.shift.tap_fwd  = ntm_fixed_pkg::gain_t'($urandom);
    h.gamma          = ntm_head_pkg::gamma_t'(1 + $urandom_range(2));
    return h;
  endfunction

  // Drive one start and queue its expected result
  task automatic issue_request(input ntm_head_pkg::head_params_t h, input vec_t c,
                               input vec_t p);
    expect_t                e;
    ntm_fixed_pkg::weight_t c_d[];
    ntm_fixed_pkg::weight_t p_d[];
    ntm_fixed_pkg::weight_t o_d[];
    c_d = new[ELEMENTS];
    p_d = new[ELEMENTS];
    for (int j = 0; j < ELEMENTS; j++) begin
      c_d[j] = c[j];
      p_d[j] = p[j];
    end
    model_request(h, c_d, p_d, o_d);
    e.test_id = cur_test;
    for (int j = 0; j < ELEMENTS; j++) begin
      e.w[j] = o_d[j];
    end
    @(posedge CLK);
    e.issue_cycle = cycle_cnt + 1;
    start  <= 1'b1;
    head   <= h;
    wc     <= c;
    w_prev <= p;
    exp_q.push_back(e);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      start <= 1'b0;
    end
  endtask

  // Wait for every outstanding result, bounded
  task automatic drain_pipeline();
    int waited;
    waited = 0;
    idle_cycles(1);
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge CLK);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout in %s: %0d results never came out", test_names[cur_test],
               exp_q.size());
      test_errors[cur_test] += exp_q.size();
      exp_q.delete();
    end
  endtask

  task automatic report_test(input int id);
    $display("%-12s checks %0d errors %0d %s", test_names[id], test_checks[id],
             test_errors[id], (test_errors[id] == 0) ? "ok" : "FAILED");
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    ntm_head_pkg::head_params_t h;
    vec_t one_hot;
    int   failed_tests;
    int   all_checks;
    void'($urandom(32'h155c14ae));
    test_names[0] = "reset";
    test_names[1] = "latency";
    test_names[2] = "interp";
    test_names[3] = "shift";
    test_names[4] = "sharpen";
    test_names[5] = "random";
    for (int i = 0; i < NUM_TESTS; i++) begin
      test_checks[i] = 0;
      test_errors[i] = 0;
    end
    CLK      = 1'b0;
    RST      = 1'b1;
    start    = 1'b0;
    head     = '0;
    wc       = '0;
    w_prev   = '0;
    cur_test = 0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    // Quiet outputs before any start
    repeat (10) begin
      @(negedge CLK);
      test_checks[0]++;
      if (done !== 1'b0 || w_out !== '0) begin
        $display("ERROR reset: expected done 0 w_out %h actual done %b w_out %h",
                 vec_t'(0), done, w_out);
        test_errors[0]++;
      end
    end
    report_test(0);

    // Single start, then four back to back
    cur_test = 1;
    issue_request(random_head(), random_vec(), random_vec());
    idle_cycles(6);
    repeat (4) issue_request(random_head(), random_vec(), random_vec());
    drain_pipeline();
    report_test(1);

    // Gate at both ends, pass-through kernel
    cur_test = 2;
    h = '0;
    h.shift.tap_stay = 8'd255;
    h.gamma = 2'd1;
    h.g = 8'd0;
    issue_request(h, random_vec(), random_vec());
    h.g = 8'd255;
    issue_request(h, random_vec(), random_vec());
    drain_pipeline();
    report_test(2);

    // Last element must wrap to element 0
    cur_test = 3;
    one_hot = '0;
    one_hot[ELEMENTS-1] = 8'hff;
    h = '0;
    h.g = ntm_fixed_pkg::gain_t'($urandom);
    h.shift.tap_fwd = 8'd255;
    h.gamma = 2'd1;
    issue_request(h, one_hot, one_hot);
    // Full taps overflow and clamp
    h.shift = '1;
    issue_request(h, '1, '1);
    issue_request(h, random_vec(), random_vec());
    drain_pipeline();
    report_test(3);

    cur_test = 4;
    for (int i = 0; i < 8; i++) begin
      h = random_head();
      h.gamma = (i % 2 == 0) ? 2'd2 : 2'd3;
      issue_request(h, random_vec(), random_vec());
    end
    drain_pipeline();
    report_test(4);

    cur_test = 5;
    repeat (RANDOM_REQS) begin
      issue_request(random_head(), random_vec(), random_vec());
      idle_cycles($urandom_range(3));
    end
    drain_pipeline();
    report_test(5);

    failed_tests = 0;
    all_checks = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      all_checks += test_checks[i];
      if (test_errors[i] != 0) begin
        failed_tests++;
      end
    end
    $display("Tests %0d, failed %0d, checks %0d", NUM_TESTS, failed_tests, all_checks);
    if (failed_tests == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
rtl/ntm_fixed_pkg.sv
rtl/ntm_head_pkg.sv
rtl/ntm_interpolation.sv
rtl/ntm_shift_convolution.sv
rtl/ntm_sharpening.sv
rtl/ntm_addressing.sv
testbench/ntm_addressing_tb.sv

//--- Makefile
TOP := ntm_addressing_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)
	verilator --lint-only -Wall rtl/ntm_fixed_pkg.sv rtl/ntm_head_pkg.sv \
		rtl/ntm_interpolation.sv rtl/ntm_shift_convolution.sv rtl/ntm_sharpening.sv \
		rtl/ntm_addressing.sv --top-module ntm_addressing

clean:
	rm -rf obj_dir sim.log
